/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* rtl/dtcm_bank.sv */
`timescale 1ns/1ps

module dtcm_bank #(
	parameter int aw = 8
) (
	input  logic                        CLK,
	input  logic [aw-1:0]               row,
	input  logic                        wen,
	input  logic [lsu_pkg::xbytes-1:0]  mask,
	input  logic [lsu_pkg::xlen-1:0]    wdata,
	output logic [lsu_pkg::xlen-1:0]    rdata
);

	import lsu_pkg::*;

	// Rows in this bank
	localparam int depth = 2 ** aw;

	// Storage split in byte lanes for masked writes
	logic [xbytes-1:0][7:0] mem [depth];

	// Read row captured at the edge
	logic [aw-1:0] row_q;

	// Byte-masked write, lands at the edge
	always_ff @(posedge CLK) begin
		if (wen) begin
			for (int i = 0; i < xbytes; i++) begin
				// Only the enabled lanes change
				if (mask[i]) begin
					mem[row][i] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Address register for the read port
	// Load rows are taken on every edge
	always_ff @(posedge CLK) begin
		row_q <= row;
	end

	// Read data one cycle after the row was presented
	// A write at the previous edge is already visible here
	assign rdata = mem[row_q];

endmodule

/* rtl/load_align.sv */
`timescale 1ns/1ps

module load_align (
	input  logic [lsu_pkg::xlen-1:0]  rdata_a,
	input  logic [lsu_pkg::xlen-1:0]  rdata_b,
	input  lsu_pkg::mem_size_e        size,
	input  logic                      is_unsigned,
	input  logic [3:0]                low_addr,
	output logic [lsu_pkg::xlen-1:0]  data
);

	import lsu_pkg::*;

	// Two bank words in address order
	logic [2*xlen-1:0] window;

	// Window shifted so the access starts at bit 0
	logic [2*xlen-1:0] shifted;

	// Lowest doubleword of the shifted window
	logic [xlen-1:0] field;

	// Odd start puts bank B first
	// Bank A then holds the following doubleword
	assign window = low_addr[3] ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// Drop the bytes below the access
	assign shifted = window >> {low_addr[2:0], 3'b000};

	assign field = shifted[xlen-1:0];

	// Pick the width, then extend to xlen
	always_comb begin
		case (size)
			size_b: begin
				if (is_unsigned) begin
					data = {{(xlen-8){1'b0}}, field[7:0]};
				end else begin
					data = {{(xlen-8){field[7]}}, field[7:0]};
				end
			end
			size_h: begin
				if (is_unsigned) begin
					data = {{(xlen-16){1'b0}}, field[15:0]};
				end else begin
					data = {{(xlen-16){field[15]}}, field[15:0]};
				end
			end
			size_w: begin
				if (is_unsigned) begin
					data = {{(xlen-32){1'b0}}, field[31:0]};
				end else begin
					data = {{(xlen-32){field[31]}}, field[31:0]};
				end
			end
			default: begin
				// Full doubleword, nothing to extend
				data = field;
			end
		endcase
	end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

module lsu #(
	parameter int aw = 8
) (
	input  logic                       CLK,
	input  logic                       rst,

	// Load request
	input  logic                       lu_valid,
	input  lsu_pkg::mem_size_e         lu_size,
	input  logic                       lu_unsigned,
	input  logic [lsu_pkg::xlen-1:0]   lu_addr,
	input  logic [lsu_pkg::rd_w-1:0]   lu_rd,

	// Store request
	input  logic                       su_valid,
	input  lsu_pkg::mem_size_e         su_size,
	input  logic [lsu_pkg::xlen-1:0]   su_addr,
	input  logic [lsu_pkg::xlen-1:0]   su_data,
	input  logic [lsu_pkg::rd_w-1:0]   su_rd,
	output logic                       su_ready,

	input  logic                       flush,

	// Write-back
	output logic                       wb_valid,
	output logic [lsu_pkg::rd_w-1:0]   wb_rd,
	output logic [lsu_pkg::xlen-1:0]   wb_data
);

	import lsu_pkg::*;

	// Handshake results for this cycle
	logic load_go;
	logic store_go;
	logic any_go;

	// Operation steered into the store lane
	logic [xlen-1:0] sel_addr;
	mem_size_e sel_size;
	logic [rd_w-1:0] sel_rd;

	// Per-bank rows, enables and write data
	logic [aw-1:0] row_a;
	logic [aw-1:0] row_b;
	logic [xbytes-1:0] mask_a;
	logic [xbytes-1:0] mask_b;
	logic [xlen-1:0] wdata_a;
	logic [xlen-1:0] wdata_b;
	logic bank_wen;

	// Bank read ports
	logic [xlen-1:0] rdata_a;
	logic [xlen-1:0] rdata_b;

	// Load fields kept for the aligner
	mem_size_e ld_size_q;
	logic ld_unsigned_q;
	logic [3:0] ld_low_q;

	// Loads win, a store waits while a load is offered
	assign su_ready = ~lu_valid;
	assign load_go = lu_valid;
	assign store_go = su_valid & su_ready;
	assign any_go = load_go | store_go;

	// Active address, size and tag
	assign sel_addr = lu_valid ? lu_addr : su_addr;
	assign sel_size = lu_valid ? lu_size : su_size;
	assign sel_rd = lu_valid ? lu_rd : su_rd;

	// Both banks write together, masks pick the bytes
	assign bank_wen = store_go;

	store_lane #(
		.aw(aw)
	) u_store_lane (
		.addr    (sel_addr),
		.size    (sel_size),
		.data    (su_data),
		.row_a   (row_a),
		.row_b   (row_b),
		.mask_a  (mask_a),
		.mask_b  (mask_b),
		.wdata_a (wdata_a),
		.wdata_b (wdata_b)
	);

	// Even doublewords
	dtcm_bank #(
		.aw(aw)
	) bank_a (
		.CLK   (CLK),
		.row   (row_a),
		.wen   (bank_wen),
		.mask  (mask_a),
		.wdata (wdata_a),
		.rdata (rdata_a)
	);

	// Odd doublewords
	dtcm_bank #(
		.aw(aw)
	) bank_b (
		.CLK   (CLK),
		.row   (row_b),
		.wen   (bank_wen),
		.mask  (mask_b),
		.wdata (wdata_b),
		.rdata (rdata_b)
	);

	// Capture size, sign mode and offset alongside the bank read
	always_ff @(posedge CLK) begin
		if (load_go) begin
			ld_size_q <= lu_size;
			ld_unsigned_q <= lu_unsigned;
			ld_low_q <= lu_addr[3:0];
		end
	end

	// Strobe one cycle after acceptance unless flushed
	// Tag holds its last value between operations
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_valid <= any_go & ~flush;
			if (any_go) begin
				wb_rd <= sel_rd;
			end
		end
	end

	load_align u_load_align (
		.rdata_a     (rdata_a),
		.rdata_b     (rdata_b),
		.size        (ld_size_q),
		.is_unsigned (ld_unsigned_q),
		.low_addr    (ld_low_q),
		.data        (wb_data)
	);

endmodule

/* rtl/lsu_pkg.sv */
package lsu_pkg;

	// Data path width of the core
	localparam int xlen = 64;

	// Bytes per doubleword, also byte lanes per bank
	localparam int xbytes = xlen / 8;

	// Architectural register index bits
	localparam int reg_w = 5;

	// Extra bits from the rename stage
	localparam int rn_w = 2;

	// Destination tag carried to write-back
	localparam int rd_w = reg_w + rn_w;

	// Access width of a load or store
	typedef enum logic [1:0] {
		size_b = 2'd0,
		size_h = 2'd1,
		size_w = 2'd2,
		size_d = 2'd3
	} mem_size_e;

	// Unshifted byte enables for an access of the given width
	// Bit 0 is the lowest addressed byte
	function automatic logic [xbytes-1:0] size_mask(mem_size_e size);
		logic [xbytes-1:0] m;
		case (size)
			size_b: begin
				m = 8'b0000_0001;
			end
			size_h: begin
				m = 8'b0000_0011;
			end
			size_w: begin
				m = 8'b0000_1111;
			end
			default: begin
				m = 8'b1111_1111;
			end
		endcase
		return m;
	endfunction

endpackage

/* rtl/store_lane.sv */
`timescale 1ns/1ps

module store_lane #(
	parameter int aw = 8
) (
	input  logic [lsu_pkg::xlen-1:0]    addr,
	input  lsu_pkg::mem_size_e          size,
	input  logic [lsu_pkg::xlen-1:0]    data,
	output logic [aw-1:0]               row_a,
	output logic [aw-1:0]               row_b,
	output logic [lsu_pkg::xbytes-1:0]  mask_a,
	output logic [lsu_pkg::xbytes-1:0]  mask_b,
	output logic [lsu_pkg::xlen-1:0]    wdata_a,
	output logic [lsu_pkg::xlen-1:0]    wdata_b
);

	import lsu_pkg::*;

	// Byte offset inside the first doubleword
	logic [2:0] offset;

	// Access starts in an odd doubleword, i.e. in bank B
	logic odd_dw;

	// Row shared by both banks of one 16-byte window
	logic [aw-1:0] row_base;

	// Enables and data over a 16-byte window
	// Low half belongs to the starting doubleword
	logic [2*xbytes-1:0] mask_win;
	logic [2*xlen-1:0] data_win;

	assign offset = addr[2:0];
	assign odd_dw = addr[3];

	// Bits above the bank depth are dropped
	assign row_base = addr[4 +: aw];

	// Slide the size mask up to the byte offset
	assign mask_win = {{xbytes{1'b0}}, size_mask(size)} << offset;

	// Same slide for the data, in bits
	assign data_win = {{xlen{1'b0}}, data} << {offset, 3'b000};

	// Bank B always sees the row of the current window
	assign row_b = row_base;

	// Odd start spills into bank A of the next window
	assign row_a = odd_dw ? row_base + aw'(1) : row_base;

	// Swap halves so each bank gets its own lanes
	always_comb begin
		if (odd_dw) begin
			// First doubleword sits in bank B
			mask_b = mask_win[xbytes-1:0];
			mask_a = mask_win[2*xbytes-1:xbytes];
			wdata_b = data_win[xlen-1:0];
			wdata_a = data_win[2*xlen-1:xlen];
		end else begin
			// First doubleword sits in bank A
			mask_a = mask_win[xbytes-1:0];
			mask_b = mask_win[2*xbytes-1:xbytes];
			wdata_a = data_win[xlen-1:0];
			wdata_b = data_win[2*xlen-1:xlen];
		end
	end

endmodule

/* include/lsu_tb_ops.svh */
`ifndef LSU_TB_OPS_SVH
`define LSU_TB_OPS_SVH

// Write-back seen one cycle after acceptance
typedef struct packed {
	logic valid;
	logic is_load;
	logic [rd_w-1:0] rd;
	logic [xlen-1:0] data;
} wb_exp_t;

// Byte image of the 4 KiB memory
logic [7:0] ref_mem [4096];
bit written [4096];

// Pending write-back entries in acceptance order
wb_exp_t exp_q [$];

// Tags handed out in sequence
logic [rd_w-1:0] next_rd = '0;

// Clear the low address bits for a naturally aligned access
function automatic logic [xlen-1:0] aligned(logic [xlen-1:0] a, mem_size_e size);
	return a & ~((xlen'(1) << size) - xlen'(1));
endfunction

// Expected load result from the byte image
function automatic logic [xlen-1:0] model_load(logic [xlen-1:0] addr, mem_size_e size,
		logic uns);
	logic [xlen-1:0] v;
	logic [11:0] idx;
	int nb;
	v = '0;
	nb = 1 << size;
	for (int i = 0; i < nb; i++) begin
		// Wraps at the end of memory
		idx = addr[11:0] + 12'(i);
		v[8*i +: 8] = ref_mem[idx];
	end
	// Sign of the top loaded byte fills the rest
	if (!uns && nb < 8 && v[8*nb-1]) begin
		for (int i = nb; i < 8; i++) begin
			v[8*i +: 8] = 8'hff;
		end
	end
	return v;
endfunction

// Mirror an accepted store, lowest byte first
function automatic void model_store(logic [xlen-1:0] addr, mem_size_e size,
		logic [xlen-1:0] data);
	logic [11:0] idx;
	for (int i = 0; i < (1 << size); i++) begin
		idx = addr[11:0] + 12'(i);
		ref_mem[idx] = data[8*i +: 8];
		written[idx] = 1'b1;
	end
endfunction

// Loads only read bytes that hold known data
task automatic require_written(input logic [xlen-1:0] addr, input mem_size_e size);
	logic [11:0] idx;
	for (int i = 0; i < (1 << size); i++) begin
		idx = addr[11:0] + 12'(i);
		if (!written[idx]) begin
			stop_on_error($sformatf("Load at %h reads a byte that was never stored", addr));
		end
	end
endtask

// Offer a store, hold it until su_ready at an edge
task automatic store_op(input logic [xlen-1:0] addr, input mem_size_e size,
		input logic [xlen-1:0] data, input logic fl);
	wb_exp_t e;
	lu_valid = 1'b0;
	su_valid = 1'b1;
	su_size = size;
	su_addr = addr;
	su_data = data;
	su_rd = next_rd;
	flush = fl;
	@(posedge CLK);
	while (!su_ready) begin
		@(posedge CLK);
	end
	model_store(addr, size, data);
	e = '{valid: ~fl, is_load: 1'b0, rd: next_rd, data: '0};
	exp_q.push_back(e);
	fresh = 1'b0;
	next_rd = next_rd + rd_w'(1);
	@(negedge CLK);
endtask

// Loads are taken at the next edge
task automatic load_op(input logic [xlen-1:0] addr, input mem_size_e size,
		input logic uns, input logic fl);
	wb_exp_t e;
	require_written(addr, size);
	su_valid = 1'b0;
	lu_valid = 1'b1;
	lu_size = size;
	lu_unsigned = uns;
	lu_addr = addr;
	lu_rd = next_rd;
	flush = fl;
	@(posedge CLK);
	e = '{valid: ~fl, is_load: 1'b1, rd: next_rd, data: model_load(addr, size, uns)};
	exp_q.push_back(e);
	fresh = 1'b0;
	next_rd = next_rd + rd_w'(1);
	@(negedge CLK);
endtask

// Drop both requests for n cycles
task automatic idle_op(input int n);
	lu_valid = 1'b0;
	su_valid = 1'b0;
	flush = 1'b0;
	repeat (n) @(negedge CLK);
endtask

`endif

/* sim/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

	import lsu_pkg::*;

	// Operation counts of each test phase
	localparam int n_fill = 512;
	localparam int n_aligned = 60;
	localparam int n_pair = 10;
	localparam int n_flush = 10;
	localparam int n_burst = 32;

	// About one cycle per op and two for each load/store pair
	localparam int op_count = n_fill + 3 * n_aligned + 5 * 22 + 4 * n_pair
		+ 3 * n_flush + n_burst;
	localparam int max_cycles = 3 * op_count + 100;

	logic CLK;
	logic rst;
	logic lu_valid;
	mem_size_e lu_size;
	logic lu_unsigned;
	logic [xlen-1:0] lu_addr;
	logic [rd_w-1:0] lu_rd;
	logic su_valid;
	mem_size_e su_size;
	logic [xlen-1:0] su_addr;
	logic [xlen-1:0] su_data;
	logic [rd_w-1:0] su_rd;
	logic su_ready;
	logic flush;
	logic wb_valid;
	logic [rd_w-1:0] wb_rd;
	logic [xlen-1:0] wb_data;

	// Expected write-back for the current cycle
	logic exp_valid = 1'b0;
	logic exp_load = 1'b0;
	logic [rd_w-1:0] exp_rd = '0;
	logic [xlen-1:0] exp_data = '0;

	// High until the first operation is accepted
	logic fresh = 1'b1;

	int cycles = 0;

	// Report, then end the run
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	`include "lsu_tb_ops.svh"

	// Store held off in the same cycle as a load
	task automatic load_store_pair(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
		wb_exp_t e;
		require_written(addr, size_d);
		lu_valid = 1'b1;
		lu_size = size_d;
		lu_unsigned = 1'b0;
		lu_addr = addr;
		lu_rd = next_rd;
		su_valid = 1'b1;
		su_size = size_d;
		su_addr = addr;
		su_data = data;
		su_rd = next_rd + rd_w'(1);
		flush = 1'b0;
		@(posedge CLK);
		// Load sees memory before the store
		e = '{valid: 1'b1, is_load: 1'b1, rd: next_rd, data: model_load(addr, size_d, 1'b0)};
		exp_q.push_back(e);
		@(negedge CLK);
		lu_valid = 1'b0;
		@(posedge CLK);
		while (!su_ready) begin
			@(posedge CLK);
		end
		model_store(addr, size_d, data);
		e = '{valid: 1'b1, is_load: 1'b0, rd: next_rd + rd_w'(1), data: '0};
		exp_q.push_back(e);
		next_rd = next_rd + rd_w'(2);
		@(negedge CLK);
	endtask

	lsu #(
		.aw(8)
	) uut (
		.CLK         (CLK),
		.rst         (rst),
		.lu_valid    (lu_valid),
		.lu_size     (lu_size),
		.lu_unsigned (lu_unsigned),
		.lu_addr     (lu_addr),
		.lu_rd       (lu_rd),
		.su_valid    (su_valid),
		.su_size     (su_size),
		.su_addr     (su_addr),
		.su_data     (su_data),
		.su_rd       (su_rd),
		.su_ready    (su_ready),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Entry accepted at the last edge becomes this cycle's expectation
	always @(negedge CLK) begin
		if (exp_q.size() > 0) begin
			{exp_valid, exp_load, exp_rd, exp_data} = exp_q.pop_front();
		end else begin
			exp_valid = 1'b0;
			exp_load = 1'b0;
		end
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > max_cycles) begin
			stop_on_error($sformatf("Timeout: run still busy after %0d cycles", max_cycles));
		end
	end

	a_idle: assert property (@(posedge CLK) disable iff (rst)
		fresh |-> (!wb_valid && wb_rd == '0))
		else stop_on_error($sformatf("MISMATCH at %0t: write-back active before any operation",
			$time));
	a_ready: assert property (@(posedge CLK) disable iff (rst) su_ready == !lu_valid)
		else stop_on_error($sformatf("MISMATCH at %0t: su_ready is %0b with lu_valid %0b",
			$time, su_ready, lu_valid));
	a_valid: assert property (@(posedge CLK) disable iff (rst) wb_valid == exp_valid)
		else stop_on_error($sformatf("MISMATCH at %0t: wb_valid is %0b, expected %0b",
			$time, wb_valid, exp_valid));
	a_rd: assert property (@(posedge CLK) disable iff (rst) exp_valid |-> wb_rd == exp_rd)
		else stop_on_error($sformatf("MISMATCH at %0t: wb_rd is %h, expected %h",
			$time, wb_rd, exp_rd));
	a_data: assert property (@(posedge CLK) disable iff (rst)
		(exp_valid && exp_load) |-> wb_data == exp_data)
		else stop_on_error($sformatf("MISMATCH at %0t: wb_data is %h, expected %h",
			$time, wb_data, exp_data));

	initial begin : stimulus
		logic [xlen-1:0] a;
		mem_size_e sz;
		void'($urandom(25));
		rst = 1'b1;
		lu_valid = 1'b0;
		lu_size = size_b;
		lu_unsigned = 1'b0;
		lu_addr = '0;
		lu_rd = '0;
		su_valid = 1'b0;
		su_size = size_b;
		su_addr = '0;
		su_data = '0;
		su_rd = '0;
		flush = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		idle_op(3);
		// Every doubleword gets known data
		for (int k = 0; k < n_fill; k++) begin
			store_op(xlen'(k) << 3, size_d, {$urandom, $urandom}, 1'b0);
		end
		// Aligned round trips with a signed and an unsigned load
		repeat (n_aligned) begin
			sz = mem_size_e'($urandom % 4);
			a = aligned({$urandom, $urandom}, sz);
			store_op(a, sz, {$urandom, $urandom}, 1'b0);
			load_op(a, sz, 1'b0, 1'b0);
			load_op(a, sz, 1'b1, 1'b0);
		end
		// Offsets crossing 8 and 16 byte lines with whole neighbor reads
		for (int off = 5; off < 16; off++) begin
			for (int k = 0; k < 2; k++) begin
				sz = (k == 0) ? size_w : size_d;
				a = {$urandom, $urandom} & ~xlen'(15);
				store_op(a + xlen'(off), sz, {$urandom, $urandom}, 1'b0);
				load_op(a + xlen'(off), sz, 1'($urandom % 2), 1'b0);
				load_op(a, size_d, 1'b0, 1'b0);
				load_op(a + xlen'(8), size_d, 1'b0, 1'b0);
				load_op(a + xlen'(16), size_d, 1'b0, 1'b0);
			end
		end
		idle_op(2);
		// Load wins and the store lands a cycle later
		repeat (n_pair) begin
			a = aligned({$urandom, $urandom}, size_d);
			load_store_pair(a, {$urandom, $urandom});
			load_op(a, size_d, 1'b0, 1'b0);
		end
		// Flushed ops give no strobe but the store still writes
		repeat (n_flush) begin
			sz = mem_size_e'($urandom % 4);
			a = aligned({$urandom, $urandom}, sz);
			store_op(a, sz, {$urandom, $urandom}, 1'b1);
			load_op(a, sz, 1'b0, 1'b1);
			load_op(a, sz, 1'b1, 1'b0);
		end
		idle_op(3);
		// Back-to-back loads anywhere in memory
		repeat (n_burst) begin
			load_op({$urandom, $urandom}, mem_size_e'($urandom % 4), 1'($urandom % 2), 1'b0);
		end
		idle_op(4);
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
rtl/lsu_pkg.sv
rtl/dtcm_bank.sv
rtl/store_lane.sv
rtl/load_align.sv
rtl/lsu.sv
sim/lsu_tb.sv
